// File: flist.f
hw/ptw_pkg.sv
hw/ptw_miss_queue.sv
hw/ptw_tran_buf.sv
hw/ptw_walk_ctrl.sv
hw/ptw_top.sv
bench/ptw_assert.sv
bench/ptw_tb.sv

// File: Bender.yml
package:
  name: ptw

sources:
  - hw/ptw_pkg.sv
  - hw/ptw_miss_queue.sv
  - hw/ptw_tran_buf.sv
  - hw/ptw_walk_ctrl.sv
  - hw/ptw_top.sv
  - target: simulation
    files:
      - bench/ptw_assert.sv
      - bench/ptw_tb.sv

// File: bench/ptw_tb.sv
// Sparse table memory answers out of order; unmapped table reads return an invalid PTE
`timescale 1ns/1ps

module ptw_tb;

localparam logic [31:0] LFSR_SEED = 32'ha4d7;
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
localparam int WAIT_LIMIT = 2000;

// Expected TLB write as entry number plus payload
typedef struct packed {
	logic [6:0]          entryno;
	ptw_pkg::tlb_entry_t ent;
} exp_wr_t;

// Reference walk outcome
typedef struct packed {
	logic            fault;
	ptw_pkg::paddr_t fault_adr;
	exp_wr_t         wr;
} walk_res_t;

logic clk;
logic rst;
logic miss_i;
ptw_pkg::vaddr_t miss_adr_i;
ptw_pkg::asid_t miss_asid_i;
logic in_que_o;
logic missq_full_o;
logic mem_req_o;
ptw_pkg::paddr_t mem_adr_o;
ptw_pkg::tid_t mem_tid_o;
logic mem_resp_i;
ptw_pkg::tid_t mem_resp_tid_i;
ptw_pkg::pte_t mem_resp_dat_i;
logic tlb_wr_o;
logic tlb_way_o;
logic [6:0] tlb_entryno_o;
ptw_pkg::tlb_entry_t tlb_entry_o;
logic reg_cs_i;
logic reg_we_i;
logic [1:0] reg_adr_i;
logic [63:0] reg_wdat_i;
logic [63:0] reg_rdat_o;
logic fault_irq_o;

// Testbench state
logic [31:0] lfsr_q = LFSR_SEED;
ptw_pkg::pte_t page_mem [ptw_pkg::paddr_t];
ptw_pkg::paddr_t pend_adr [$];
ptw_pkg::tid_t pend_tid [$];
logic mem_hold = 1'b0;
exp_wr_t exp_q [$];
logic exp_way = 1'b0;
int req_cnt = 0;
int err_cnt = 0;
ptw_pkg::root_reg_t sw_root = '0;

ptw_top uut (
	.clk(clk), .rst(rst),
	.miss_i(miss_i), .miss_adr_i(miss_adr_i), .miss_asid_i(miss_asid_i),
	.in_que_o(in_que_o), .missq_full_o(missq_full_o),
	.mem_req_o(mem_req_o), .mem_adr_o(mem_adr_o), .mem_tid_o(mem_tid_o),
	.mem_resp_i(mem_resp_i), .mem_resp_tid_i(mem_resp_tid_i),
	.mem_resp_dat_i(mem_resp_dat_i),
	.tlb_wr_o(tlb_wr_o), .tlb_way_o(tlb_way_o), .tlb_entryno_o(tlb_entryno_o),
	.tlb_entry_o(tlb_entry_o),
	.reg_cs_i(reg_cs_i), .reg_we_i(reg_we_i), .reg_adr_i(reg_adr_i),
	.reg_wdat_i(reg_wdat_i), .reg_rdat_o(reg_rdat_o), .fault_irq_o(fault_irq_o)
);

initial clk = 1'b0;
always #2 clk = ~clk;

// ========================================
// Helpers
// ========================================
// Galois LFSR stepping once per bit taken
function automatic logic [31:0] lfsr_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsr_q[0]};
		lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
	end
	return v;
endfunction

function automatic ptw_pkg::pte_t read_pte(input ptw_pkg::paddr_t adr);
	if (page_mem.exists(adr))
		return page_mem[adr];
	return '0;
endfunction

// Leaf PTE whose upper bits vary with the page so payload mixups show
function automatic ptw_pkg::pte_t leaf_pte(input ptw_pkg::vaddr_t va);
	return {16'h00c3, va[31:16], va[31:16] ^ 16'h7000, 16'h0f03};
endfunction

// Level-0 table reached through the level-1 entry at va[31:29]
function automatic ptw_pkg::paddr_t l0_table(input ptw_pkg::vaddr_t va);
	return {16'h0020 + 16'(va[31:29]), 16'h0000};
endfunction

// Expected outcome of one miss from the address format rules
function automatic walk_res_t ref_walk(input ptw_pkg::root_reg_t root,
		input ptw_pkg::vaddr_t va, input ptw_pkg::asid_t asid);
	walk_res_t res;
	ptw_pkg::paddr_t adr;
	ptw_pkg::pte_t pte;
	res = '0;
	adr = {root.base[31:3], 3'b000};
	if (root.level) begin
		adr = adr + {26'd0, va[31:29], 3'b000};
		pte = read_pte(adr);
		if (!pte[0]) begin
			res.fault = 1'b1;
			res.fault_adr = adr;
			return res;
		end
		// Next table from the PTE page number
		adr = {pte[31:16], va[28:16], 3'b000};
	end else begin
		adr = adr + {16'd0, va[28:16], 3'b000};
	end
	pte = read_pte(adr);
	if (!pte[0]) begin
		res.fault = 1'b1;
		res.fault_adr = adr;
	end else begin
		res.wr.entryno = va[22:16];
		res.wr.ent.vpn = va[31:23];
		res.wr.ent.asid = asid;
		res.wr.ent.pte = pte;
	end
	return res;
endfunction

task automatic stop_run();
	$display("Done: errors found");
	$fatal(1, "run stopped on first failure");
endtask

task automatic check_eq(input string what, input logic [127:0] got, input logic [127:0] exp);
	if (got !== exp) begin
		err_cnt++;
		$display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
		stop_run();
	end
endtask

task automatic map_leaf(input ptw_pkg::paddr_t tbl, input ptw_pkg::vaddr_t va);
	page_mem[tbl + {16'd0, va[28:16], 3'b000}] = leaf_pte(va);
endtask

task automatic reg_write(input logic [1:0] adr, input logic [63:0] dat);
	@(negedge clk);
	reg_cs_i = 1'b1;
	reg_we_i = 1'b1;
	reg_adr_i = adr;
	reg_wdat_i = dat;
	@(negedge clk);
	reg_cs_i = 1'b0;
	reg_we_i = 1'b0;
endtask

// Read data is registered and taken one cycle after select
task automatic reg_read(input logic [1:0] adr, output logic [63:0] dat);
	@(negedge clk);
	reg_cs_i = 1'b1;
	reg_we_i = 1'b0;
	reg_adr_i = adr;
	@(negedge clk);
	reg_cs_i = 1'b0;
	dat = reg_rdat_o;
endtask

task automatic set_root(input ptw_pkg::root_reg_t root);
	reg_write(ptw_pkg::REG_ROOT, root);
	sw_root = root;
endtask

// Memory hold changes away from the falling edge the model uses
task automatic hold_memory(input logic v);
	@(posedge clk);
	mem_hold = v;
endtask

// One-cycle miss strobe; accepted misses that walk cleanly join the expected set
task automatic send_miss(input ptw_pkg::vaddr_t va, input ptw_pkg::asid_t asid,
		output logic q_seen, output logic full_seen, output walk_res_t res);
	@(negedge clk);
	miss_i = 1'b1;
	miss_adr_i = va;
	miss_asid_i = asid;
	#1;
	q_seen = in_que_o;
	full_seen = missq_full_o;
	res = ref_walk(sw_root, va, asid);
	if (!q_seen && !full_seen && !res.fault)
		exp_q.push_back(res.wr);
	@(negedge clk);
	miss_i = 1'b0;
endtask

task automatic wait_drained();
	int n;
	n = 0;
	while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
		@(negedge clk);
		#1;
		n++;
	end
	if (exp_q.size() != 0) begin
		$display("Timeout: %0d expected TLB writes never arrived", exp_q.size());
		stop_run();
	end
endtask

task automatic wait_fault();
	int n;
	n = 0;
	while (!fault_irq_o && n < WAIT_LIMIT) begin
		@(negedge clk);
		#1;
		n++;
	end
	if (!fault_irq_o) begin
		$display("Timeout: the fault interrupt never rose");
		stop_run();
	end
endtask

// ========================================
// Memory model and checker
// ========================================
// Takes requests on the falling edge and answers a random pending one
always @(negedge clk) begin : mem_model
	int k;
	mem_resp_i = 1'b0;
	if (mem_req_o) begin
		req_cnt++;
		pend_adr.push_back(mem_adr_o);
		pend_tid.push_back(mem_tid_o);
	end
	// Four or more pending forces an answer
	if (!mem_hold && pend_tid.size() > 0) begin
		if (pend_tid.size() >= 4 || lfsr_bits(2) == 32'd0) begin
			k = int'(lfsr_bits(4)) % pend_tid.size();
			mem_resp_i = 1'b1;
			mem_resp_tid_i = pend_tid[k];
			mem_resp_dat_i = read_pte(pend_adr[k]);
			pend_adr.delete(k);
			pend_tid.delete(k);
		end
	end
end

// Each TLB write must match one pending expected entry
always @(negedge clk) begin : tlb_checker
	int hit;
	hit = -1;
	if (!rst && tlb_wr_o) begin
		foreach (exp_q[i]) begin
			if (hit < 0 && exp_q[i].entryno == tlb_entryno_o &&
					exp_q[i].ent.vpn == tlb_entry_o.vpn &&
					exp_q[i].ent.asid == tlb_entry_o.asid)
				hit = i;
		end
		check_eq("TLB write matches a pending miss", hit >= 0, 1'b1);
		check_eq("TLB entry", {tlb_entryno_o, tlb_entry_o}, exp_q[hit]);
		check_eq("TLB way", tlb_way_o, exp_way);
		exp_way = ~exp_way;
		exp_q.delete(hit);
	end
end

// ========================================
// Stimulus
// ========================================
initial begin : stimulus
	ptw_pkg::root_reg_t root1;
	ptw_pkg::root_reg_t root0;
	ptw_pkg::vaddr_t va;
	walk_res_t res;
	walk_res_t fres;
	logic [63:0] rd;
	logic q_seen;
	logic full_seen;
	int base_cnt;
	int k;
	rst = 1'b1;
	miss_i = 1'b0;
	miss_adr_i = '0;
	miss_asid_i = '0;
	mem_resp_i = 1'b0;
	mem_resp_tid_i = '0;
	mem_resp_dat_i = '0;
	reg_cs_i = 1'b0;
	reg_we_i = 1'b0;
	reg_adr_i = '0;
	reg_wdat_i = '0;
	// Level-1 table with index 7 left invalid
	for (k = 0; k < 7; k++)
		page_mem[32'h0001_0000 + 32'(k * 8)] = {32'h0, 16'h0020 + 16'(k), 16'h0e01};
	repeat (10) @(negedge clk);
	rst = 1'b0;

	// Root readback and a two-level walk
	root1 = '0;
	root1.level = 1'b1;
	root1.base = 32'h0001_0000;
	set_root(root1);
	reg_read(ptw_pkg::REG_ROOT, rd);
	check_eq("root register readback", rd, root1);
	va = 32'h2345_0000;
	map_leaf(l0_table(va), va);
	send_miss(va, 16'h0011, q_seen, full_seen, res);
	wait_drained();

	// Start level 0 with one read per miss
	root0 = '0;
	root0.base = 32'h0040_0000;
	set_root(root0);
	va = 32'h7abc_0000;
	map_leaf(32'h0040_0000, va);
	base_cnt = req_cnt;
	send_miss(va, 16'h0022, q_seen, full_seen, res);
	wait_drained();
	check_eq("one table read from start level 0", req_cnt - base_cnt, 1);

	// Same page twice while the first walk is held
	set_root(root1);
	va = 32'h4111_0000;
	map_leaf(l0_table(va), va);
	hold_memory(1'b1);
	send_miss(va, 16'h0033, q_seen, full_seen, res);
	check_eq("first miss not a duplicate", q_seen, 1'b0);
	send_miss(va | 32'h0000_1234, 16'h0033, q_seen, full_seen, res);
	check_eq("repeated miss flagged in queue", q_seen, 1'b1);
	hold_memory(1'b0);
	wait_drained();

	// Fill all eight slots so the ninth is dropped
	hold_memory(1'b1);
	for (k = 0; k < 8; k++) begin
		va = {3'(k % 7), 13'(k * 613 + 9), 16'h0000};
		map_leaf(l0_table(va), va);
		send_miss(va, 16'h0200 + 16'(k), q_seen, full_seen, res);
		check_eq("queue not yet full", full_seen, 1'b0);
	end
	send_miss(32'h0cc0_0000, 16'h0299, q_seen, full_seen, res);
	check_eq("ninth miss sees a full queue", full_seen, 1'b1);
	hold_memory(1'b0);
	wait_drained();

	// Invalid level-1 entry with two good walks pending
	hold_memory(1'b1);
	send_miss(32'he001_0000, 16'h0bad, q_seen, full_seen, fres);
	for (k = 0; k < 2; k++) begin
		va = {3'(k + 2), 13'(k * 101 + 77), 16'h0000};
		map_leaf(l0_table(va), va);
		send_miss(va, 16'h0300 + 16'(k), q_seen, full_seen, res);
	end
	hold_memory(1'b0);
	wait_fault();
	reg_read(ptw_pkg::REG_FAULT_ASID, rd);
	check_eq("fault asid register", rd, 64'h0bad);
	reg_read(ptw_pkg::REG_FAULT_ADR, rd);
	check_eq("fault address register", rd, fres.fault_adr);
	check_eq("fault cleared by address read", fault_irq_o, 1'b0);
	wait_drained();

	if (err_cnt == 0)
		$display("Done: no errors");
	else
		$display("Done: errors found");
	$finish;
end

endmodule

// File: bench/ptw_assert.sv
// Bound to ptw_top; way check expects way 0 on the first TLB write after reset
`timescale 1ns/1ps

module ptw_assert (
	input logic       clk,
	input logic       rst,
	input logic       mem_req_o,
	input logic       tlb_wr_o,
	input logic       tlb_way_o,
	input logic       fault_irq_o,
	input logic       reg_cs_i,
	input logic       reg_we_i,
	input logic [1:0] reg_adr_i
);

// Way of the previous write starts at 1 so the first write must use 0
logic last_way;

always_ff @(posedge clk or posedge rst) begin
	if (rst)
		last_way <= 1'b1;
	else if (tlb_wr_o)
		last_way <= tlb_way_o;
end

a_reset_quiet: assert property (@(posedge clk) rst |-> !tlb_wr_o && !mem_req_o)
	else $error("memory request or TLB write during reset");

a_no_req_in_fault: assert property (@(posedge clk) disable iff (rst)
	fault_irq_o |-> !mem_req_o)
	else $error("memory request while the fault is pending");

a_way_toggle: assert property (@(posedge clk) disable iff (rst)
	tlb_wr_o |-> tlb_way_o != last_way)
	else $error("TLB way did not alternate");

a_fault_clear: assert property (@(posedge clk) disable iff (rst)
	$fell(fault_irq_o) |->
		$past(reg_cs_i && !reg_we_i && reg_adr_i == ptw_pkg::REG_FAULT_ADR))
	else $error("fault interrupt fell without a fault address read");

endmodule

bind ptw_top ptw_assert u_assert (
	.clk(clk), .rst(rst),
	.mem_req_o(mem_req_o), .tlb_wr_o(tlb_wr_o), .tlb_way_o(tlb_way_o),
	.fault_irq_o(fault_irq_o),
	.reg_cs_i(reg_cs_i), .reg_we_i(reg_we_i), .reg_adr_i(reg_adr_i)
);

// File: hw/ptw_top.sv
// Memory port has no back-pressure and must return at most one response per cycle
`timescale 1ns/1ps

module ptw_top (
	input  logic                          clk,
	input  logic                          rst,
	// Miss port
	input  logic                          miss_i,
	input  ptw_pkg::vaddr_t               miss_adr_i,
	input  ptw_pkg::asid_t                miss_asid_i,
	output logic                          in_que_o,
	output logic                          missq_full_o,
	// Memory port
	output logic                          mem_req_o,
	output ptw_pkg::paddr_t               mem_adr_o,
	output ptw_pkg::tid_t                 mem_tid_o,
	input  logic                          mem_resp_i,
	input  ptw_pkg::tid_t                 mem_resp_tid_i,
	input  ptw_pkg::pte_t                 mem_resp_dat_i,
	// TLB port
	output logic                          tlb_wr_o,
	output logic                          tlb_way_o,
	output logic [ptw_pkg::ENTRYNO_W-1:0] tlb_entryno_o,
	output ptw_pkg::tlb_entry_t           tlb_entry_o,
	// Register port
	input  logic                          reg_cs_i,
	input  logic                          reg_we_i,
	input  logic [1:0]                    reg_adr_i,
	input  logic [63:0]                   reg_wdat_i,
	output logic [63:0]                   reg_rdat_o,
	output logic                          fault_irq_o
);

ptw_pkg::issue_t issue;
ptw_pkg::ready_t ready;
ptw_pkg::walk_step_t step;
ptw_pkg::root_reg_t root;
logic done;
logic hold;

// Issue record doubles as the memory request
assign mem_req_o = issue.valid;
assign mem_adr_o = issue.paddr;
assign mem_tid_o = issue.tid;

ptw_miss_queue u_missq (
	.clk(clk), .rst(rst),
	.miss_i(miss_i), .miss_adr_i(miss_adr_i), .miss_asid_i(miss_asid_i),
	.root_i(root), .hold_i(hold), .step_i(step),
	.in_que_o(in_que_o), .missq_full_o(missq_full_o), .issue_o(issue)
);

ptw_tran_buf u_tranbuf (
	.clk(clk), .rst(rst),
	.issue_i(issue),
	.resp_i(mem_resp_i), .resp_tid_i(mem_resp_tid_i), .resp_dat_i(mem_resp_dat_i),
	.done_i(done), .ready_o(ready)
);

ptw_walk_ctrl u_walk (
	.clk(clk), .rst(rst),
	.ready_i(ready),
	.reg_cs_i(reg_cs_i), .reg_we_i(reg_we_i), .reg_adr_i(reg_adr_i),
	.reg_wdat_i(reg_wdat_i), .reg_rdat_o(reg_rdat_o),
	.done_o(done), .step_o(step), .hold_o(hold), .root_o(root),
	.tlb_wr_o(tlb_wr_o), .tlb_way_o(tlb_way_o), .tlb_entryno_o(tlb_entryno_o),
	.tlb_entry_o(tlb_entry_o), .fault_irq_o(fault_irq_o)
);

endmodule

// File: hw/ptw_walk_ctrl.sv
// Only the first fault is kept; a second invalid PTE waits in the buffer until the fault is read
`timescale 1ns/1ps

module ptw_walk_ctrl (
	input  logic                          clk,
	input  logic                          rst,
	input  ptw_pkg::ready_t               ready_i,
	input  logic                          reg_cs_i,
	input  logic                          reg_we_i,
	input  logic [1:0]                    reg_adr_i,
	input  logic [63:0]                   reg_wdat_i,
	output logic [63:0]                   reg_rdat_o,
	output logic                          done_o,
	output ptw_pkg::walk_step_t           step_o,
	output logic                          hold_o,
	output ptw_pkg::root_reg_t            root_o,
	output logic                          tlb_wr_o,
	output logic                          tlb_way_o,
	output logic [ptw_pkg::ENTRYNO_W-1:0] tlb_entryno_o,
	output ptw_pkg::tlb_entry_t           tlb_entry_o,
	output logic                          fault_irq_o
);

typedef enum logic {
	IDLE  = 1'b0,
	FAULT = 1'b1
} state_t;

state_t state_q;
ptw_pkg::root_reg_t root_q;
ptw_pkg::paddr_t fault_adr_q;
ptw_pkg::asid_t fault_asid_q;
logic way_q;
logic pte_v;
logic last_lvl;
logic take;
logic raise_fault;
logic do_tlb;
logic rd_fault;
logic wr_root;

// ========================================
// PTE evaluation
// ========================================
assign pte_v = ready_i.pte[ptw_pkg::PTE_V_BIT];
assign last_lvl = (ready_i.level == 1'b0);

// In FAULT a second invalid PTE is left pending
assign take = ready_i.valid && (pte_v || state_q == IDLE);
assign raise_fault = take && !pte_v;
assign do_tlb = take && pte_v && last_lvl;
assign done_o = take;

// Next table is always level 0 and indexed by va[28:16]
always_comb begin
	step_o.valid = take;
	step_o.slot = ready_i.slot;
	step_o.retire = !pte_v || last_lvl;
	step_o.paddr = {ready_i.pte[ptw_pkg::PTE_PPN_LSB +: $bits(ptw_pkg::ppn_t)],
		ready_i.vaddr[ptw_pkg::L0_IDX_LSB +: ptw_pkg::L0_IDX_W], 3'b000};
end

// Issue stops while the fault is up and in the cycle that raises it
assign hold_o = (state_q == FAULT) || raise_fault;
assign fault_irq_o = (state_q == FAULT);
assign root_o = root_q;

// ========================================
// Fault state machine
// ========================================
assign rd_fault = reg_cs_i && !reg_we_i && reg_adr_i == ptw_pkg::REG_FAULT_ADR;
assign wr_root = reg_cs_i && reg_we_i && reg_adr_i == ptw_pkg::REG_ROOT;

always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		state_q <= IDLE;
	end else begin
		case (state_q)
			IDLE: if (raise_fault) state_q <= FAULT;
			FAULT: if (rd_fault) state_q <= IDLE;
			default: state_q <= IDLE;
		endcase
	end
end

// Software registers with read data one cycle after select
always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		root_q <= '0;
		fault_adr_q <= '0;
		fault_asid_q <= '0;
		reg_rdat_o <= '0;
	end else begin
		if (wr_root)
			root_q <= ptw_pkg::root_reg_t'(reg_wdat_i);
		// Table address of the invalid PTE
		if (raise_fault) begin
			fault_adr_q <= ready_i.paddr;
			fault_asid_q <= ready_i.asid;
		end
		if (reg_cs_i && !reg_we_i) begin
			case (reg_adr_i)
				ptw_pkg::REG_FAULT_ADR: reg_rdat_o <= 64'(fault_adr_q);
				ptw_pkg::REG_FAULT_ASID: reg_rdat_o <= 64'(fault_asid_q);
				ptw_pkg::REG_ROOT: reg_rdat_o <= root_q;
				default: reg_rdat_o <= '0;
			endcase
		end
	end
end

// ========================================
// TLB write
// ========================================
// Way flips once per write and the first write uses way 0
always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		tlb_wr_o <= 1'b0;
		tlb_way_o <= 1'b0;
		way_q <= 1'b0;
	end else begin
		tlb_wr_o <= do_tlb;
		if (do_tlb) begin
			tlb_way_o <= way_q;
			way_q <= ~way_q;
		end
	end
end

always_ff @(posedge clk) begin
	if (do_tlb) begin
		tlb_entryno_o <= ready_i.vaddr[ptw_pkg::L0_IDX_LSB +: ptw_pkg::ENTRYNO_W];
		tlb_entry_o.vpn <= ready_i.vaddr[ptw_pkg::VPN_TAG_LSB +: ptw_pkg::VPN_TAG_W];
		tlb_entry_o.asid <= ready_i.asid;
		tlb_entry_o.pte <= ready_i.pte;
	end
end

endmodule

// File: hw/ptw_tran_buf.sv
// Tids roll over in 16; a record must retire before its tid comes round again
`timescale 1ns/1ps

module ptw_tran_buf (
	input  logic              clk,
	input  logic              rst,
	input  ptw_pkg::issue_t   issue_i,
	input  logic              resp_i,
	input  ptw_pkg::tid_t     resp_tid_i,
	input  ptw_pkg::pte_t     resp_dat_i,
	input  logic              done_i,
	output ptw_pkg::ready_t   ready_o
);

// Read in flight, indexed by tid
typedef struct packed {
	ptw_pkg::slot_t  slot;
	ptw_pkg::level_t lvl;
	ptw_pkg::asid_t  asid;
	ptw_pkg::vaddr_t vaddr;
	ptw_pkg::paddr_t paddr;
	ptw_pkg::pte_t   pte;
} tran_rec_t;

logic [ptw_pkg::TRAN_DEPTH-1:0] rec_v;
logic [ptw_pkg::TRAN_DEPTH-1:0] rec_rdy;
tran_rec_t rec [ptw_pkg::TRAN_DEPTH];
logic resp_hit;
logic sel_found;
ptw_pkg::tid_t sel_tid;

// Response for a live record, or for one being recorded on the same edge
assign resp_hit = resp_i &&
	(rec_v[resp_tid_i] || (issue_i.valid && issue_i.tid == resp_tid_i));

// ========================================
// Record state
// ========================================
always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		rec_v <= '0;
		rec_rdy <= '0;
	end else begin
		// Presented record consumed by the controller
		if (done_i && sel_found) begin
			rec_v[sel_tid] <= 1'b0;
			rec_rdy[sel_tid] <= 1'b0;
		end
		if (issue_i.valid) begin
			rec_v[issue_i.tid] <= 1'b1;
			rec_rdy[issue_i.tid] <= 1'b0;
		end
		// Later assignment wins over a same-edge issue
		if (resp_hit)
			rec_rdy[resp_tid_i] <= 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (issue_i.valid) begin
		rec[issue_i.tid].slot <= issue_i.slot;
		rec[issue_i.tid].lvl <= issue_i.level;
		rec[issue_i.tid].asid <= issue_i.asid;
		rec[issue_i.tid].vaddr <= issue_i.vaddr;
		rec[issue_i.tid].paddr <= issue_i.paddr;
	end
	if (resp_hit)
		rec[resp_tid_i].pte <= resp_dat_i;
end

// ========================================
// Ready selection
// ========================================
// Highest ready index wins
always_comb begin
	sel_found = 1'b0;
	sel_tid = '0;
	for (int i = 0; i < ptw_pkg::TRAN_DEPTH; i++) begin
		if (rec_rdy[i]) begin
			sel_found = 1'b1;
			sel_tid = ptw_pkg::tid_t'(i);
		end
	end
	ready_o.valid = sel_found;
	ready_o.slot = rec[sel_tid].slot;
	ready_o.level = rec[sel_tid].lvl;
	ready_o.asid = rec[sel_tid].asid;
	ready_o.vaddr = rec[sel_tid].vaddr;
	ready_o.paddr = rec[sel_tid].paddr;
	ready_o.pte = rec[sel_tid].pte;
end

endmodule

// File: hw/ptw_miss_queue.sv
// Duplicates are matched on asid and 64 KiB page; a miss offered while full is dropped silently
`timescale 1ns/1ps

module ptw_miss_queue (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   miss_i,
	input  ptw_pkg::vaddr_t        miss_adr_i,
	input  ptw_pkg::asid_t         miss_asid_i,
	input  ptw_pkg::root_reg_t     root_i,
	input  logic                   hold_i,
	input  ptw_pkg::walk_step_t    step_i,
	output logic                   in_que_o,
	output logic                   missq_full_o,
	output ptw_pkg::issue_t        issue_o
);

// Per-miss walk data, control bits kept apart
typedef struct packed {
	ptw_pkg::level_t lvl;
	ptw_pkg::asid_t  asid;
	ptw_pkg::vaddr_t vaddr;
	ptw_pkg::paddr_t taddr;
} miss_ent_t;

logic [ptw_pkg::MISSQ_DEPTH-1:0] ent_v;
logic [ptw_pkg::MISSQ_DEPTH-1:0] ent_wait;
miss_ent_t ent [ptw_pkg::MISSQ_DEPTH];
logic free_found;
ptw_pkg::slot_t free_slot;
logic sel_found;
ptw_pkg::slot_t sel_slot;
logic accept;
logic do_issue;
ptw_pkg::paddr_t root_base;
ptw_pkg::paddr_t first_adr;
ptw_pkg::tid_t tid_q;
logic issue_v_q;
ptw_pkg::issue_t issue_pl_q;

// ========================================
// Capture side
// ========================================
// Same asid and same page already queued
always_comb begin
	in_que_o = 1'b0;
	for (int i = 0; i < ptw_pkg::MISSQ_DEPTH; i++) begin
		if (ent_v[i] && ent[i].asid == miss_asid_i &&
				ent[i].vaddr[31:ptw_pkg::L0_IDX_LSB] == miss_adr_i[31:ptw_pkg::L0_IDX_LSB])
			in_que_o = miss_i;
	end
end

assign missq_full_o = &ent_v;
assign accept = miss_i && !in_que_o && !missq_full_o;

// Lowest free slot
always_comb begin
	free_found = 1'b0;
	free_slot = '0;
	for (int i = 0; i < ptw_pkg::MISSQ_DEPTH; i++) begin
		if (!ent_v[i] && !free_found) begin
			free_found = 1'b1;
			free_slot = ptw_pkg::slot_t'(i);
		end
	end
end

// First table address from root base plus start level index
always_comb begin
	root_base = {root_i.base[31:3], 3'b000};
	if (root_i.level)
		first_adr = root_base +
			ptw_pkg::paddr_t'({miss_adr_i[ptw_pkg::L1_IDX_LSB +: ptw_pkg::L1_IDX_W], 3'b000});
	else
		first_adr = root_base +
			ptw_pkg::paddr_t'({miss_adr_i[ptw_pkg::L0_IDX_LSB +: ptw_pkg::L0_IDX_W], 3'b000});
end

// ========================================
// Issue side
// ========================================
// Lowest entry waiting for its next read
always_comb begin
	sel_found = 1'b0;
	sel_slot = '0;
	for (int i = 0; i < ptw_pkg::MISSQ_DEPTH; i++) begin
		if (ent_v[i] && ent_wait[i] && !sel_found) begin
			sel_found = 1'b1;
			sel_slot = ptw_pkg::slot_t'(i);
		end
	end
end

assign do_issue = sel_found && !hold_i;

always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		ent_v <= '0;
		ent_wait <= '0;
		tid_q <= '0;
		issue_v_q <= 1'b0;
	end else begin
		if (accept) begin
			ent_v[free_slot] <= 1'b1;
			ent_wait[free_slot] <= 1'b1;
		end
		issue_v_q <= do_issue;
		if (do_issue) begin
			ent_wait[sel_slot] <= 1'b0;
			tid_q <= tid_q + 1'b1;
		end
		// Retire frees the slot, otherwise the next level waits for issue
		if (step_i.valid) begin
			if (step_i.retire)
				ent_v[step_i.slot] <= 1'b0;
			else
				ent_wait[step_i.slot] <= 1'b1;
		end
	end
end

// Walk data and read record
always_ff @(posedge clk) begin
	if (accept) begin
		ent[free_slot].lvl <= root_i.level;
		ent[free_slot].asid <= miss_asid_i;
		ent[free_slot].vaddr <= miss_adr_i;
		ent[free_slot].taddr <= first_adr;
	end
	if (do_issue) begin
		ent[sel_slot].lvl <= ent[sel_slot].lvl - 1'b1;
		issue_pl_q <= '{valid: 1'b1, tid: tid_q, slot: sel_slot,
			level: ent[sel_slot].lvl, asid: ent[sel_slot].asid,
			vaddr: ent[sel_slot].vaddr, paddr: ent[sel_slot].taddr};
	end
	if (step_i.valid && !step_i.retire)
		ent[step_i.slot].taddr <= step_i.paddr;
end

// One-cycle strobe, payload held
always_comb begin
	issue_o = issue_pl_q;
	issue_o.valid = issue_v_q;
end

endmodule

// File: hw/ptw_pkg.sv
// Two-level walk with 64 KiB pages on 32-bit addresses; one 64-bit PTE per read, no attribute register
package ptw_pkg;

// ========================================
// Vector types
// ========================================
typedef logic [31:0] vaddr_t;
typedef logic [31:0] paddr_t;
typedef logic [15:0] asid_t;
typedef logic [15:0] ppn_t;
typedef logic [3:0]  tid_t;
typedef logic [2:0]  slot_t;
typedef logic        level_t;
typedef logic [63:0] pte_t;

// Queue and transaction buffer sizes, matching slot_t and tid_t
localparam int MISSQ_DEPTH = 8;
localparam int TRAN_DEPTH  = 16;

// Register word offsets
localparam logic [1:0] REG_FAULT_ADR  = 2'd0;
localparam logic [1:0] REG_FAULT_ASID = 2'd1;
localparam logic [1:0] REG_ROOT       = 2'd2;

// PTE fields
localparam int PTE_V_BIT   = 0;
localparam int PTE_PPN_LSB = 16;

// Virtual address fields
localparam int L1_IDX_LSB  = 29;
localparam int L1_IDX_W    = 3;
localparam int L0_IDX_LSB  = 16;
localparam int L0_IDX_W    = 13;
localparam int VPN_TAG_LSB = 23;
localparam int VPN_TAG_W   = 9;
localparam int ENTRYNO_W   = 7;

// ========================================
// Register layouts and block links
// ========================================
// Root register, base bits 2..0 are ignored
typedef struct packed {
	logic [30:0] rsvd;
	level_t      level;
	paddr_t      base;
} root_reg_t;

typedef struct packed {
	logic [VPN_TAG_W-1:0] vpn;
	asid_t                asid;
	pte_t                 pte;
} tlb_entry_t;

// One table read leaving the miss queue
typedef struct packed {
	logic   valid;
	tid_t   tid;
	slot_t  slot;
	level_t level;
	asid_t  asid;
	vaddr_t vaddr;
	paddr_t paddr;
} issue_t;

// Controller verdict for one queue slot
typedef struct packed {
	logic   valid;
	slot_t  slot;
	logic   retire;
	paddr_t paddr;
} walk_step_t;

// Completed read handed to the controller
typedef struct packed {
	logic   valid;
	slot_t  slot;
	level_t level;
	asid_t  asid;
	vaddr_t vaddr;
	paddr_t paddr;
	pte_t   pte;
} ready_t;

endpackage
